//--- common/datapathCtrlIf.sv
// controller commands to the datapath and flags back, connected inside proc
`timescale 1ns/1ps

interface datapathCtrlIf import procIsaPkg::*, procCtrlPkg::*; ();

    busSelT      busSel;    // bus source this cycle
    logic [7:0]  regLoad;   // one-hot, bit 7 loads the pc
    logic        pcIncr;
    logic        aLoad;
    logic        gLoad;
    aluOpT       aluOp;
    logic        flagLoad;  // only in T4 of add, sub, and
    wordT        immWord;   // sign-extended, or shifted by 8 for mvt
    flagsT       flags;

    modport ctrl (
        output busSel, regLoad, pcIncr, aLoad, gLoad, aluOp, flagLoad, immWord,
        input  flags
    );

    modport dp (
        input  busSel, regLoad, pcIncr, aLoad, gLoad, aluOp, flagLoad, immWord,
        output flags
    );

endinterface

//--- common/memCtrlIf.sv
// memory-port load strobes and the bus value feeding the output registers
`timescale 1ns/1ps

interface memCtrlIf import procIsaPkg::*; ();

    logic addrLoad;   // bus into addr
    logic doutLoad;   // bus into dataOut
    logic writeNext;  // write strobe, one cycle ahead
    wordT bus;        // internal bus from the datapath

    modport ctrl (output addrLoad, doutLoad, writeNext);

    modport dp (output bus);

    modport port (input addrLoad, doutLoad, writeNext, bus);

endinterface

//--- common/procCtrlPkg.sv
// control encodings passed from the processor controller to its datapath
package procCtrlPkg;

    // time steps of one instruction, at most six
    typedef enum logic [2:0] {
        T0 = 3'd0,  // fetch, pc onto addr
        T1 = 3'd1,  // memory wait
        T2 = 3'd2,  // ir load
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5
    } tStepT;

    // internal bus sources; r0..r7 line up with the register number
    typedef enum logic [3:0] {
        busR0  = 4'd0,
        busR1  = 4'd1,
        busR2  = 4'd2,
        busR3  = 4'd3,
        busR4  = 4'd4,
        busR5  = 4'd5,
        busR6  = 4'd6,
        busPc  = 4'd7,
        busG   = 4'd8,
        busImm = 4'd9,   // extended immediate from the controller
        busDin = 4'd10   // memory read data
    } busSelT;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2
    } aluOpT;

endpackage

//--- common/procIsaPkg.sv
// instruction set types for the 16-bit multicycle processor, imported by RTL and testbench
package procIsaPkg;

    typedef logic [15:0] wordT;   // data and address word

    typedef logic [2:0] regIdxT;  // r0..r7, r7 is the pc

    // 3-bit opcode field, 111 has no instruction
    typedef enum logic [2:0] {
        opMv  = 3'b000,
        opMvt = 3'b001,  // imm clear means b{cond}
        opAdd = 3'b010,
        opSub = 3'b011,
        opLd  = 3'b100,
        opSt  = 3'b101,
        opAnd = 3'b110
    } opcodeT;

    // branch condition, carried in the rX field
    typedef enum logic [2:0] {
        condAlways = 3'b000,
        condEq     = 3'b001,  // zero set
        condNe     = 3'b010,
        condCc     = 3'b011,  // carry clear
        condCs     = 3'b100,
        condPl     = 3'b101,  // negative clear
        condMi     = 3'b110
    } condT;  // 111 also branches

    // instruction word: III M XXX DDDDDDDDD
    typedef struct packed {
        opcodeT      opcode;
        logic        imm;    // data is an immediate
        regIdxT      rX;
        logic [8:0]  data;   // rY in the low 3 bits when imm is clear
    } instrT;

    // condition flags, written by add, sub and and only
    typedef struct packed {
        logic carry;
        logic negative;
        logic zero;
    } flagsT;

endpackage

//--- datapath/procAlu.sv
// add, subtract and bitwise and for proc, with the carry, negative and zero flags
`timescale 1ns/1ps

module procAlu import procIsaPkg::*, procCtrlPkg::*; (
    input  logic  Clock,
    input  logic  arstN,
    input  wordT  a,         // from A
    input  wordT  b,         // from the bus
    input  aluOpT aluOp,
    input  logic  flagLoad,
    output wordT  result,
    output flagsT flags
);

    logic carryOut;

    always_comb begin
        case (aluOp)
            aluSub: {carryOut, result} = {1'b0, a} + {1'b0, ~b} + 17'd1;  // two's complement
            aluAnd: begin
                carryOut = 1'b0;  // and clears carry
                result = a & b;
            end
            default: {carryOut, result} = {1'b0, a} + {1'b0, b};
        endcase
    end

    // captured at the edge ending T4
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (flagLoad) begin
            flags.carry <= carryOut;
            flags.negative <= result[15];
            flags.zero <= (result == 16'd0);
        end
    end

endmodule

//--- datapath/procDatapath.sv
// register file, program counter, bus multiplexer and ALU operand registers of proc
`timescale 1ns/1ps

module procDatapath import procIsaPkg::*, procCtrlPkg::*; #(
    parameter wordT ResetPc = '0  // first fetch address
) (
    input  logic        Clock,
    input  logic        arstN,
    input  wordT        dataIn,   // memory read data, bus source for ld
    datapathCtrlIf.dp   dpCtrl,
    memCtrlIf.dp        memBus
);

    wordT regFile [7];  // r0..r6
    wordT pc;           // r7
    wordT aReg;         // ALU left operand
    wordT gReg;         // ALU result
    wordT bus;
    wordT aluResult;

    // single internal bus
    always_comb begin
        case (dpCtrl.busSel)
            busR0:   bus = regFile[0];
            busR1:   bus = regFile[1];
            busR2:   bus = regFile[2];
            busR3:   bus = regFile[3];
            busR4:   bus = regFile[4];
            busR5:   bus = regFile[5];
            busR6:   bus = regFile[6];
            busPc:   bus = pc;
            busG:    bus = gReg;
            busImm:  bus = dpCtrl.immWord;
            busDin:  bus = dataIn;
            default: bus = '0;
        endcase
    end

    assign memBus.bus = bus;  // addr and dataOut load from here

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 7; i++)
                regFile[i] <= '0;
        end else begin
            for (int i = 0; i < 7; i++)
                if (dpCtrl.regLoad[i])
                    regFile[i] <= bus;
        end
    end

    // load beats increment, so mv r7 or a taken branch wins
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN)
            pc <= ResetPc;
        else if (dpCtrl.regLoad[7])
            pc <= bus;
        else if (dpCtrl.pcIncr)
            pc <= pc + 16'd1;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            aReg <= '0;
            gReg <= '0;
        end else begin
            if (dpCtrl.aLoad)
                aReg <= bus;
            if (dpCtrl.gLoad)
                gReg <= aluResult;  // written back in T5
        end
    end

    // right operand straight off the bus
    procAlu i_procAlu (
        .Clock    (Clock),
        .arstN    (arstN),
        .a        (aReg),
        .b        (bus),
        .aluOp    (dpCtrl.aluOp),
        .flagLoad (dpCtrl.flagLoad),
        .result   (aluResult),
        .flags    (dpCtrl.flags)
    );

endmodule

//--- design/memPort.sv
// registered address, write data and write strobe toward the external synchronous memory
`timescale 1ns/1ps

module memPort import procIsaPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    memCtrlIf.port   memCtrl,
    output wordT     addr,
    output wordT     dataOut,
    output logic     write
);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            addr <= '0;
            dataOut <= '0;
            write <= 1'b0;
        end else begin
            if (memCtrl.addrLoad)
                addr <= memCtrl.bus;     // fetch pc or rY
            if (memCtrl.doutLoad)
                dataOut <= memCtrl.bus;  // rX of st
            write <= memCtrl.writeNext;  // one-cycle strobe
        end
    end

endmodule

//--- design/proc.sv
// top level of the 16-bit multicycle processor, wiring controller, datapath and memory port
`timescale 1ns/1ps

module proc import procIsaPkg::*; #(
    parameter wordT ResetPc = '0  // address of the first fetch
) (
    input  logic Clock,
    input  logic arstN,
    input  logic run,      // level, holds the fetch in T0 when low
    input  wordT dataIn,   // memory read data
    output wordT dataOut,  // memory write data
    output wordT addr,
    output logic write     // high for one cycle per st
);

    datapathCtrlIf dpCtrl ();
    memCtrlIf      memCtrl ();

    procController i_procController (
        .Clock   (Clock),
        .arstN   (arstN),
        .run     (run),
        .dataIn  (dataIn),
        .dpCtrl  (dpCtrl.ctrl),
        .memCtrl (memCtrl.ctrl)
    );

    procDatapath #(
        .ResetPc (ResetPc)
    ) i_procDatapath (
        .Clock  (Clock),
        .arstN  (arstN),
        .dataIn (dataIn),
        .dpCtrl (dpCtrl.dp),
        .memBus (memCtrl.dp)
    );

    memPort i_memPort (
        .Clock   (Clock),
        .arstN   (arstN),
        .memCtrl (memCtrl.port),
        .addr    (addr),
        .dataOut (dataOut),
        .write   (write)
    );

endmodule

//--- design/procController.sv
// time-step FSM, instruction register and decode driving the datapath and memory port
`timescale 1ns/1ps

module procController import procIsaPkg::*, procCtrlPkg::*; (
    input  logic         Clock,
    input  logic         arstN,
    input  logic         run,       // gates the fetch in T0
    input  wordT         dataIn,    // instruction word arrives here in T2
    datapathCtrlIf.ctrl  dpCtrl,
    memCtrlIf.ctrl       memCtrl
);

    tStepT  tStep;
    tStepT  tStepNext;
    instrT  ir;
    logic   irLoad;
    logic   done;      // instruction ends after this step
    logic   condMet;   // branch condition true
    logic   loadRx;
    logic   loadPc;    // branch target into r7
    busSelT rxSel;
    busSelT rySel;

    // register numbers map straight onto the bus select codes
    assign rxSel = busSelT'({1'b0, ir.rX});
    assign rySel = busSelT'({1'b0, ir.data[2:0]});

    // mvt puts the low byte in the upper half, all other users sign-extend
    always_comb begin
        if (ir.opcode == opMvt && ir.imm)
            dpCtrl.immWord = {ir.data[7:0], 8'h00};
        else
            dpCtrl.immWord = {{7{ir.data[8]}}, ir.data};
    end

    always_comb begin
        case (condT'(ir.rX))
            condEq:  condMet = dpCtrl.flags.zero;
            condNe:  condMet = !dpCtrl.flags.zero;
            condCc:  condMet = !dpCtrl.flags.carry;
            condCs:  condMet = dpCtrl.flags.carry;
            condPl:  condMet = !dpCtrl.flags.negative;
            condMi:  condMet = dpCtrl.flags.negative;
            default: condMet = 1'b1;  // always, and code 111
        endcase
    end

    always_comb begin
        irLoad = 1'b0;  // everything idle unless a step asks
        done = 1'b0;
        loadRx = 1'b0;
        loadPc = 1'b0;
        dpCtrl.busSel = busG;
        dpCtrl.pcIncr = 1'b0;
        dpCtrl.aLoad = 1'b0;
        dpCtrl.gLoad = 1'b0;
        dpCtrl.aluOp = aluAdd;
        dpCtrl.flagLoad = 1'b0;
        memCtrl.addrLoad = 1'b0;
        memCtrl.doutLoad = 1'b0;
        memCtrl.writeNext = 1'b0;
        case (tStep)
            T0: begin
                dpCtrl.busSel = busPc;  // fetch address
                memCtrl.addrLoad = 1'b1;
                dpCtrl.pcIncr = run;
            end
            T1: ;                        // memory latency
            T2: irLoad = 1'b1;
            T3: begin
                case (ir.opcode)
                    opMv: begin
                        dpCtrl.busSel = ir.imm ? busImm : rySel;
                        loadRx = 1'b1;
                        done = 1'b1;
                    end
                    opMvt: begin
                        if (ir.imm) begin
                            dpCtrl.busSel = busImm;
                            loadRx = 1'b1;
                            done = 1'b1;
                        end else begin
                            dpCtrl.busSel = busPc;  // pc already points past the branch
                            dpCtrl.aLoad = 1'b1;
                            done = !condMet;        // not taken ends here
                        end
                    end
                    opAdd, opSub, opAnd: begin
                        dpCtrl.busSel = rxSel;
                        dpCtrl.aLoad = 1'b1;
                    end
                    opLd, opSt: begin
                        dpCtrl.busSel = rySel;      // memory address from rY
                        memCtrl.addrLoad = 1'b1;
                    end
                    default: done = 1'b1;           // unused opcode acts as nop
                endcase
            end
            T4: begin
                case (ir.opcode)
                    opMvt: begin                    // only taken branches get here
                        dpCtrl.busSel = busImm;
                        dpCtrl.gLoad = 1'b1;
                    end
                    opAdd, opSub, opAnd: begin
                        dpCtrl.busSel = ir.imm ? busImm : rySel;
                        dpCtrl.gLoad = 1'b1;
                        dpCtrl.flagLoad = 1'b1;
                        if (ir.opcode == opSub)
                            dpCtrl.aluOp = aluSub;
                        else if (ir.opcode == opAnd)
                            dpCtrl.aluOp = aluAnd;
                    end
                    opSt: begin
                        dpCtrl.busSel = rxSel;
                        memCtrl.doutLoad = 1'b1;
                        memCtrl.writeNext = 1'b1;  // write high during the next cycle
                        done = 1'b1;
                    end
                    default: ;                      // ld waits for its data
                endcase
            end
            T5: begin
                case (ir.opcode)
                    opMvt: begin
                        dpCtrl.busSel = busG;       // branch target
                        loadPc = 1'b1;
                    end
                    opLd: begin
                        dpCtrl.busSel = busDin;
                        loadRx = 1'b1;
                    end
                    default: begin                  // add, sub, and write back G
                        dpCtrl.busSel = busG;
                        loadRx = ir.opcode inside {opAdd, opSub, opAnd};
                    end
                endcase
            end
            default: done = 1'b1;
        endcase
    end

    // rX decode, r7 also reachable from the branch path
    assign dpCtrl.regLoad = ({7'b0, loadRx} << ir.rX) | {loadPc, 7'b0};

    always_comb begin
        case (tStep)
            T0:      tStepNext = run ? T1 : T0;
            T1:      tStepNext = T2;
            T2:      tStepNext = T3;
            T3:      tStepNext = done ? T0 : T4;
            T4:      tStepNext = done ? T0 : T5;
            default: tStepNext = T0;  // T5 always ends
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            tStep <= T0;
            ir <= '0;
        end else begin
            tStep <= tStepNext;
            if (irLoad)
                ir <= instrT'(dataIn);
        end
    end

endmodule

//--- proc.f
common/procIsaPkg.sv
common/procCtrlPkg.sv
common/datapathCtrlIf.sv
common/memCtrlIf.sv
datapath/procAlu.sv
datapath/procDatapath.sv
design/procController.sv
design/memPort.sv
design/proc.sv
verification/proc_assertions.sv
verification/procTb.sv

//--- verification/procTb.sv
// testbench for proc that runs a program table from a memory model and checks every store
`timescale 1ns/1ps

module procTb import procIsaPkg::*; ();

    localparam wordT StoreBase = 16'h00E0;  // all stores land here
    localparam int   DataBase = 8'hF0;      // random data words

    logic Clock;
    logic arstN;
    logic run;
    wordT dataIn;
    wordT dataOut;
    wordT addr;
    logic write;

    wordT mem [256];
    wordT prog [$];       // program table loaded at address 0
    wordT expAddr [$];    // expected stores
    wordT expData [$];
    wordT rv [8];         // register values predicted from the ISA rules
    wordT dataWord [4];
    wordT rdAddr;
    wordT wrData;
    logic wrEn;
    wordT stallAddr;
    wordT heldAddr;
    int   stallIdx;
    int   seed;
    int   errorCount;
    int   testCount;
    int   waitCount;
    logic timedOut;
    logic testOk;

    proc #(
        .ResetPc (16'h0000)
    ) i_proc (
        .Clock   (Clock),
        .arstN   (arstN),
        .run     (run),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .addr    (addr),
        .write   (write)
    );

    always #10 Clock = ~Clock;

    // sync memory samples the outputs mid-cycle and drives read data just after the edge
    always @(negedge Clock) begin
        rdAddr = addr;
        wrData = dataOut;
        wrEn = write;
    end

    always @(posedge Clock) begin
        #1;
        dataIn = mem[rdAddr[7:0]];  // read before write
        if (wrEn)
            mem[rdAddr[7:0]] = wrData;
    end

    function automatic wordT encode(opcodeT op, logic imm, regIdxT rx, logic [8:0] d);
        return {op, imm, rx, d};
    endfunction

    // expected flags with carry as no borrow for sub and cleared by and
    function automatic flagsT predictFlags(opcodeT op, wordT a, wordT b);
        logic [16:0] sum;
        flagsT f;
        case (op)
            opSub: begin
                sum[15:0] = a - b;
                sum[16] = (a >= b);  // no borrow
            end
            opAnd:   sum = {1'b0, a & b};
            default: sum = {1'b0, a} + {1'b0, b};
        endcase
        f.carry = sum[16];
        f.negative = sum[15];
        f.zero = (sum[15:0] == 16'd0);
        return f;
    endfunction

    function automatic logic branchTaken(logic [2:0] cond, flagsT f);
        case (cond)
            3'd1:    return f.zero;
            3'd2:    return !f.zero;
            3'd3:    return !f.carry;
            3'd4:    return f.carry;
            3'd5:    return !f.negative;
            3'd6:    return f.negative;
            default: return 1'b1;  // always and code 111
        endcase
    endfunction

    task automatic storeReg(regIdxT rx);
        prog.push_back(encode(opSt, 1'b0, rx, 9'd5));  // st rx, [r5]
        expAddr.push_back(rv[5]);
        expData.push_back(rv[rx]);
    endtask

    // flag setup then every condition with each branch skipping the not-taken marker
    task automatic addFlagScenario(wordT setup, wordT aluInstr, opcodeT op, wordT a, wordT b);
        flagsT f;
        f = predictFlags(op, a, b);
        prog.push_back(setup);
        prog.push_back(aluInstr);
        for (int c = 0; c < 8; c++) begin
            prog.push_back(encode(opMvt, 1'b0, regIdxT'(c), 9'd1));  // target = pc + 2
            prog.push_back(encode(opSt, 1'b0, 3'd1, 9'd5));
            prog.push_back(encode(opSt, 1'b0, 3'd2, 9'd5));
            if (!branchTaken(c[2:0], f)) begin
                expAddr.push_back(StoreBase);
                expData.push_back(16'd1);
            end
            expAddr.push_back(StoreBase);
            expData.push_back(16'd2);
        end
    endtask

    task automatic buildProgram();
        prog.push_back(encode(opMv, 1'b1, 3'd5, 9'h0E0));
        rv[5] = StoreBase;
        prog.push_back(encode(opMv, 1'b1, 3'd0, 9'h1FD));  // -3 sign-extended
        rv[0] = 16'hFFFD;
        storeReg(3'd0);
        stallIdx = expAddr.size() - 1;  // run drops after this store
        prog.push_back(encode(opMvt, 1'b1, 3'd1, 9'h05A));
        rv[1] = 16'h5A00;
        stallAddr = wordT'(prog.size());
        storeReg(3'd1);
        prog.push_back(encode(opMv, 1'b0, 3'd2, 9'd0));   // mv r2, r0
        rv[2] = rv[0];
        storeReg(3'd2);
        prog.push_back(encode(opAdd, 1'b0, 3'd2, 9'd1));
        rv[2] = rv[2] + rv[1];
        storeReg(3'd2);
        prog.push_back(encode(opAdd, 1'b1, 3'd2, 9'd7));
        rv[2] = rv[2] + 16'd7;
        storeReg(3'd2);
        prog.push_back(encode(opSub, 1'b0, 3'd2, 9'd0));
        rv[2] = rv[2] - rv[0];
        storeReg(3'd2);
        prog.push_back(encode(opSub, 1'b1, 3'd2, 9'h1FE)); // minus -2
        rv[2] = rv[2] - 16'hFFFE;
        storeReg(3'd2);
        prog.push_back(encode(opAnd, 1'b0, 3'd2, 9'd1));
        rv[2] = rv[2] & rv[1];
        storeReg(3'd2);
        prog.push_back(encode(opAnd, 1'b1, 3'd2, 9'h0F3));
        rv[2] = rv[2] & 16'h00F3;
        storeReg(3'd2);
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encode(opMv, 1'b1, 3'd6, 9'(DataBase + i)));
            prog.push_back(encode(opLd, 1'b0, 3'd0, 9'd6));  // ld r0, [r6]
            rv[0] = dataWord[i];
            storeReg(3'd0);
        end
        prog.push_back(encode(opMv, 1'b1, 3'd1, 9'd1));  // not-taken marker
        prog.push_back(encode(opMv, 1'b1, 3'd2, 9'd2));  // common marker
        addFlagScenario(encode(opMv, 1'b1, 3'd4, 9'd0), encode(opAdd, 1'b1, 3'd4, 9'd0),
                        opAdd, 16'h0000, 16'h0000);
        addFlagScenario(encode(opMv, 1'b1, 3'd4, 9'h1FF), encode(opAdd, 1'b1, 3'd4, 9'd1),
                        opAdd, 16'hFFFF, 16'h0001);
        addFlagScenario(encode(opMvt, 1'b1, 3'd4, 9'h080), encode(opAnd, 1'b0, 3'd4, 9'd4),
                        opAnd, 16'h8000, 16'h8000);
        addFlagScenario(encode(opMv, 1'b1, 3'd4, 9'd5), encode(opSub, 1'b1, 3'd4, 9'd3),
                        opSub, 16'h0005, 16'h0003);
        prog.push_back(encode(opMvt, 1'b0, 3'd0, 9'h1FF));  // branch to itself
    endtask

    // hold run low at T0 and watch that nothing moves
    task automatic stallCheck();
        testOk = 1'b1;
        @(posedge Clock);
        #1 run = 1'b0;
        for (int i = 0; i < 13; i++) begin  // mvt finishes in three steps and ten follow in T0
            @(negedge Clock);
            if (i == 6) begin
                heldAddr = addr;
                if (heldAddr !== stallAddr) begin
                    $display("CHECK FAILED at %0t: addr got %h expected %h",
                             $time, heldAddr, stallAddr);
                    testOk = 1'b0;
                end
            end
            if (i > 6 && addr !== heldAddr) begin
                $display("CHECK FAILED at %0t: addr got %h expected %h",
                         $time, addr, heldAddr);
                testOk = 1'b0;
            end
            if (write !== 1'b0) begin
                $display("CHECK FAILED at %0t: write got %b expected 0", $time, write);
                testOk = 1'b0;
            end
        end
        @(posedge Clock);
        #1 run = 1'b1;
        testCount++;
        if (!testOk)
            errorCount++;
        $display("test stall with run low: %s", testOk ? "ok" : "failed");
    endtask

    initial begin
        Clock = 1'b0;
        arstN = 1'b0;
        run = 1'b1;
        dataIn = '0;
        rdAddr = '0;
        wrData = '0;
        wrEn = 1'b0;
        seed = 32'h018b_89c7;
        errorCount = 0;
        testCount = 0;
        timedOut = 1'b0;
        for (int i = 0; i < 8; i++)
            rv[i] = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = 16'hC000 | wordT'(i);  // fill tied to the whole address
        for (int i = 0; i < 4; i++) begin
            dataWord[i] = 16'($random(seed));
            mem[DataBase + i] = dataWord[i];
        end
        buildProgram();
        foreach (prog[i])
            mem[i] = prog[i];

        repeat (5) @(posedge Clock);
        @(negedge Clock);
        testOk = 1'b1;
        if (write !== 1'b0) begin
            $display("CHECK FAILED at %0t: write got %b expected 0", $time, write);
            testOk = 1'b0;
        end
        if (dataOut !== 16'h0000) begin
            $display("CHECK FAILED at %0t: dataOut got %h expected 0000", $time, dataOut);
            testOk = 1'b0;
        end
        @(posedge Clock);
        #1 arstN = 1'b1;
        @(negedge Clock);
        if (addr !== 16'h0000) begin
            $display("CHECK FAILED at %0t: addr got %h expected 0000", $time, addr);
            testOk = 1'b0;
        end
        testCount++;
        if (!testOk)
            errorCount++;
        $display("test reset state: %s", testOk ? "ok" : "failed");

        for (int t = 0; t < expAddr.size() && !timedOut; t++) begin
            waitCount = 0;
            do begin
                @(negedge Clock);
                waitCount++;
            end while (write !== 1'b1 && waitCount < 200);
            if (write !== 1'b1) begin
                $display("timeout: store %0d never happened within 200 cycles", t);
                timedOut = 1'b1;
            end else begin
                testOk = 1'b1;
                if (addr !== expAddr[t]) begin
                    $display("CHECK FAILED at %0t: addr got %h expected %h",
                             $time, addr, expAddr[t]);
                    testOk = 1'b0;
                end
                if (dataOut !== expData[t]) begin
                    $display("CHECK FAILED at %0t: dataOut got %h expected %h",
                             $time, dataOut, expData[t]);
                    testOk = 1'b0;
                end
                testCount++;
                if (!testOk)
                    errorCount++;
                $display("test store %0d: %s", t, testOk ? "ok" : "failed");
                if (t == stallIdx)
                    stallCheck();
            end
        end

        $display("tests run %0d, failed %0d", testCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verification/proc_assertions.sv
// concurrent checks on the proc memory outputs, bound into every proc instance
`timescale 1ns/1ps

module proc_assertions import procIsaPkg::*; (
    input logic Clock,
    input logic arstN,
    input wordT addr,
    input wordT dataOut,
    input logic write
);

    // one store is a single-cycle strobe
    writePulse: assert property (@(posedge Clock) disable iff (!arstN)
        write |=> !write)
        else $error("write high on two consecutive cycles");

    noUnknown: assert property (@(posedge Clock) disable iff (!arstN)
        !$isunknown({addr, dataOut}))
        else $error("addr or dataOut unknown after reset");

    writeInReset: assert property (@(posedge Clock)
        !arstN |-> !write)
        else $error("write high during reset");

endmodule

bind proc proc_assertions i_procAssertions (
    .Clock   (Clock),
    .arstN   (arstN),
    .addr    (addr),
    .dataOut (dataOut),
    .write   (write)
);
